// File: Bender.yml
package:
  name: me_top

sources:
  - files:
      - design/me_pkg.sv
      - design/me_if.sv
      - design/cur_buffer.sv
      - design/ref_window.sv
      - design/sad_array.sv
      - design/min_select.sv
      - design/me_top.sv
  - target: test
    files:
      - test/tb_me_top.sv

// File: design/cur_buffer.sv
module cur_buffer
    import me_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pixel_row_t cur_in,       // 4 pixels of one row
    input  logic       cur_valid,
    input  logic       block_done,
    output logic       need_cur,     // Ask for cur_in
    output logic       cur_ready,
    output block_t     cur_block
);

    cur_state_t state;
    logic [1:0] row_cnt;
    logic       row_we;

    assign need_cur  = (state == CUR_LOAD);
    assign cur_ready = (state == CUR_HOLD);
    assign row_we    = cur_valid && need_cur;   // Strobes in HOLD are dropped

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= CUR_LOAD;
            row_cnt <= '0;
        end
        else
        begin
            case (state)
                CUR_LOAD:
                begin
                    if (row_we)
                    begin
                        row_cnt <= row_cnt + 2'd1;   // Wraps back to row 0
                        if (row_cnt == 2'd3)
                        begin
                            state <= CUR_HOLD;
                        end
                    end
                end
                CUR_HOLD:
                begin
                    if (block_done)
                    begin
                        state <= CUR_LOAD;
                    end
                end
                default:
                begin
                    state <= CUR_LOAD;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (row_we)
        begin
            cur_block[row_cnt*ROW_W +: ROW_W] <= cur_in;
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_ignore_strobe: assert property (@(posedge clk) disable iff (rst)
        cur_valid && !need_cur |=> $stable(cur_block));

endmodule

// File: design/me_if.sv
// Candidate block from the reference window to the AD array
interface cand_if
    import me_pkg::*;
();

    block_t    cand_block;   // Window in row order
    logic      cand_valid;   // One strobe per candidate
    cand_idx_t cand_index;
    logic      cand_last;    // Marks index 15

    modport src (
        output cand_block,
        output cand_valid,
        output cand_index,
        output cand_last
    );

    modport dst (
        input  cand_block,
        input  cand_valid,
        input  cand_index,
        input  cand_last
    );

endinterface

// One candidate SAD from the AD array to the minimum selector
interface sad_if
    import me_pkg::*;
();

    sad_t      sad;
    logic      sad_valid;
    cand_idx_t sad_index;
    logic      sad_last;

    modport src (
        output sad,
        output sad_valid,
        output sad_index,
        output sad_last
    );

    modport dst (
        input  sad,
        input  sad_valid,
        input  sad_index,
        input  sad_last
    );

endinterface

// File: design/me_pkg.sv
package me_pkg;

    // ----------------------------------------------------------
    // Search geometry
    // ----------------------------------------------------------
    localparam int BLOCK_EDGE   = 4;
    localparam int NUM_CAND     = 16;                          // Horizontal positions only
    localparam int WINDOW_COLS  = NUM_CAND + BLOCK_EDGE - 1;   // 19 reference columns
    localparam int BLOCK_PIXELS = BLOCK_EDGE * BLOCK_EDGE;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int PIXEL_W   = 8;
    localparam int ROW_W     = BLOCK_EDGE * PIXEL_W;
    localparam int BLOCK_W   = BLOCK_EDGE * ROW_W;
    localparam int SAD_W     = 12;                             // Worst case 16 * 255 = 4080
    localparam int IDX_W     = 4;
    localparam int COL_CNT_W = 5;

    typedef logic [PIXEL_W-1:0]   pixel_t;
    typedef logic [ROW_W-1:0]     pixel_row_t;                 // Cur row or ref column
    typedef logic [BLOCK_W-1:0]   block_t;                     // Row r at bit 32r
    typedef logic [SAD_W-1:0]     sad_t;
    typedef logic [IDX_W-1:0]     cand_idx_t;
    typedef logic [COL_CNT_W-1:0] col_cnt_t;

    typedef enum logic {CUR_LOAD, CUR_HOLD} cur_state_t;
    typedef enum logic [1:0] {REF_IDLE, REF_FILL, REF_WAIT} ref_state_t;

endpackage

// File: design/me_top.sv
module me_top
    import me_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pixel_row_t cur_in,        // 4 pixels of a current row
    input  logic       cur_valid,
    input  pixel_row_t ref_in,        // 4 pixels of a reference column
    input  logic       ref_valid,
    output logic       need_cur,      // Ask for cur_in
    output logic       need_ref,      // Ask for ref_in
    output sad_t       best_sad,
    output cand_idx_t  best_index,
    output logic       result_valid
);

    block_t cur_block;
    logic   cur_ready;
    logic   block_done;

    cand_if cand_bus ();
    sad_if  sad_bus ();

    // ----------------------------------------------------------
    // Data capture
    // ----------------------------------------------------------
    cur_buffer cur_buffer_i (
        .clk        (clk       ),
        .rst        (rst       ),
        .cur_in     (cur_in    ),
        .cur_valid  (cur_valid ),
        .block_done (block_done),
        .need_cur   (need_cur  ),
        .cur_ready  (cur_ready ),
        .cur_block  (cur_block )
    );

    ref_window ref_window_i (
        .clk        (clk       ),
        .rst        (rst       ),
        .ref_in     (ref_in    ),
        .ref_valid  (ref_valid ),
        .cur_ready  (cur_ready ),
        .block_done (block_done),
        .need_ref   (need_ref  ),
        .cand       (cand_bus  )
    );

    // ----------------------------------------------------------
    // SAD and minimum search
    // ----------------------------------------------------------
    sad_array sad_array_i (
        .clk        (clk      ),
        .rst        (rst      ),
        .cur_block  (cur_block),
        .cand       (cand_bus ),
        .sad_out    (sad_bus  )
    );

    min_select min_select_i (
        .clk          (clk         ),
        .rst          (rst         ),
        .sad_in       (sad_bus     ),
        .best_sad     (best_sad    ),
        .best_index   (best_index  ),
        .result_valid (result_valid),
        .block_done   (block_done  )
    );

endmodule

// File: design/min_select.sv
module min_select
    import me_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    sad_if.dst        sad_in,
    output sad_t      best_sad,
    output cand_idx_t best_index,
    output logic      result_valid,   // One cycle pulse
    output logic      block_done
);

    sad_t      run_sad;
    cand_idx_t run_index;
    logic      take_new;

    // Strict less than, so the lower index keeps a tie
    assign take_new = (sad_in.sad_index == '0) || (sad_in.sad < run_sad);

    always_ff @(posedge clk)
    begin
        if (sad_in.sad_valid && take_new)
        begin
            run_sad   <= sad_in.sad;
            run_index <= sad_in.sad_index;
        end
        if (sad_in.sad_valid && sad_in.sad_last)
        begin
            // Last candidate still competes here
            best_sad   <= take_new ? sad_in.sad : run_sad;
            best_index <= take_new ? sad_in.sad_index : run_index;
        end
    end

    // ----------------------------------------------------------
    // Result and end of block pulses
    // ----------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            result_valid <= 1'b0;
            block_done   <= 1'b0;
        end
        else
        begin
            result_valid <= sad_in.sad_valid && sad_in.sad_last;
            block_done   <= result_valid;   // Frees cur_buffer and ref_window
        end
    end

    a_last_index: assert property (@(posedge clk) disable iff (rst)
        sad_in.sad_valid && sad_in.sad_last |-> sad_in.sad_index == cand_idx_t'(NUM_CAND - 1));

endmodule

// File: design/ref_window.sv
module ref_window
    import me_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pixel_row_t ref_in,       // One column, row r at bit 8r
    input  logic       ref_valid,
    input  logic       cur_ready,
    input  logic       block_done,
    output logic       need_ref,     // Ask for ref_in
    cand_if.src        cand
);

    ref_state_t state;
    col_cnt_t   col_cnt;                  // Columns accepted so far
    pixel_row_t win [BLOCK_EDGE];         // win[0] is the oldest column
    logic       col_we;
    logic       valid_q;
    logic       last_q;

    assign need_ref = (state == REF_FILL);
    assign col_we   = ref_valid && need_ref;

    // ----------------------------------------------------------
    // Fill control
    // ----------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= REF_IDLE;
            col_cnt <= '0;
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end
        else
        begin
            // Fourth column onward completes a candidate
            valid_q <= col_we && (col_cnt >= col_cnt_t'(BLOCK_EDGE - 1));
            last_q  <= col_we && (col_cnt == col_cnt_t'(WINDOW_COLS - 1));
            case (state)
                REF_IDLE:
                begin
                    if (cur_ready)
                    begin
                        state <= REF_FILL;
                    end
                end
                REF_FILL:
                begin
                    if (col_we)
                    begin
                        col_cnt <= col_cnt + col_cnt_t'(1);
                        if (col_cnt == col_cnt_t'(WINDOW_COLS - 1))
                        begin
                            state <= REF_WAIT;
                        end
                    end
                end
                REF_WAIT:
                begin
                    if (block_done)
                    begin
                        state   <= REF_IDLE;
                        col_cnt <= '0;
                    end
                end
                default:
                begin
                    state <= REF_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (col_we)
        begin
            for (int i = 0; i < BLOCK_EDGE - 1; i++)
            begin
                win[i] <= win[i+1];
            end
            win[BLOCK_EDGE-1] <= ref_in;
        end
    end

    // Column order to row order
    always_comb
    begin
        for (int r = 0; r < BLOCK_EDGE; r++)
        begin
            for (int c = 0; c < BLOCK_EDGE; c++)
            begin
                cand.cand_block[(r*BLOCK_EDGE + c)*PIXEL_W +: PIXEL_W] =
                    win[c][r*PIXEL_W +: PIXEL_W];
            end
        end
    end

    assign cand.cand_valid = valid_q;
    assign cand.cand_last  = last_q;
    assign cand.cand_index = cand_idx_t'(col_cnt - col_cnt_t'(BLOCK_EDGE));

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_col_cnt_range: assert property (@(posedge clk) disable iff (rst)
        col_cnt <= col_cnt_t'(WINDOW_COLS));

    // The current block must stay loaded while columns stream in
    a_fill_with_block: assert property (@(posedge clk) disable iff (rst)
        need_ref |-> cur_ready);

endmodule

// File: design/sad_array.sv
module sad_array
    import me_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  block_t cur_block,
    cand_if.dst    cand,
    sad_if.src     sad_out
);

    pixel_t    ad_q [BLOCK_PIXELS];   // Stage 1 absolute differences
    logic      s1_valid;
    logic      s1_last;
    cand_idx_t s1_index;
    sad_t      sad_sum;
    sad_t      sad_q;                 // Stage 2
    logic      s2_valid;
    logic      s2_last;
    cand_idx_t s2_index;

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        return (a > b) ? (a - b) : (b - a);
    endfunction

    // ----------------------------------------------------------
    // Stage 1 absolute differences
    // ----------------------------------------------------------
    always_ff @(posedge clk)
    begin
        for (int p = 0; p < BLOCK_PIXELS; p++)
        begin
            ad_q[p] <= abs_diff(cur_block[p*PIXEL_W +: PIXEL_W],
                                cand.cand_block[p*PIXEL_W +: PIXEL_W]);
        end
        s1_index <= cand.cand_index;
        s2_index <= s1_index;
        sad_q    <= sad_sum;
    end

    always_comb
    begin
        sad_sum = '0;
        for (int p = 0; p < BLOCK_PIXELS; p++)
        begin
            sad_sum = sad_sum + sad_t'(ad_q[p]);   // Zero extend
        end
    end

    // ----------------------------------------------------------
    // Stage 2 sum, valid and last ride along
    // ----------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
            s2_valid <= 1'b0;
            s2_last  <= 1'b0;
        end
        else
        begin
            s1_valid <= cand.cand_valid;
            s1_last  <= cand.cand_valid && cand.cand_last;
            s2_valid <= s1_valid;
            s2_last  <= s1_last;
        end
    end

    assign sad_out.sad       = sad_q;
    assign sad_out.sad_valid = s2_valid;
    assign sad_out.sad_index = s2_index;
    assign sad_out.sad_last  = s2_last;

endmodule

// File: test/tb_me_top.sv
module tb_me_top
    import me_pkg::*;
();

    localparam int CLK_PERIOD     = 10;
    localparam int RESET_CYCLES   = 8;
    localparam int WAIT_LIMIT     = 200;   // Cycles before a wait gives up
    localparam int RESULT_LATENCY = 4;

    logic       clk = 1'b0;
    logic       rst;
    pixel_row_t cur_in;
    logic       cur_valid;
    pixel_row_t ref_in;
    logic       ref_valid;
    logic       need_cur;
    logic       need_ref;
    sad_t       best_sad;
    cand_idx_t  best_index;
    logic       result_valid;

    logic [31:0] lfsr_state;
    pixel_row_t  cur_rows [BLOCK_EDGE];    // Row r, pixel c at bit 8c
    pixel_row_t  ref_cols [WINDOW_COLS];   // Column k, row r at bit 8r
    int          checks;
    int          errors;
    int          tests;
    logic        hung;                     // Set by any timeout

    me_top dut_i (
        .clk          (clk         ),
        .rst          (rst         ),
        .cur_in       (cur_in      ),
        .cur_valid    (cur_valid   ),
        .ref_in       (ref_in      ),
        .ref_valid    (ref_valid   ),
        .need_cur     (need_cur    ),
        .need_ref     (need_ref    ),
        .best_sad     (best_sad    ),
        .best_index   (best_index  ),
        .result_valid (result_valid)
    );

    initial
    begin
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // ------------------------------------------------------------
    // Random numbers and reference model
    // ------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];       // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);   // One step per bit
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic sad_t model_sad(input int k);
        int sum;
        int d;
        sum = 0;
        for (int r = 0; r < BLOCK_EDGE; r++)
        begin
            for (int c = 0; c < BLOCK_EDGE; c++)
            begin
                d = int'(cur_rows[r][c*PIXEL_W +: PIXEL_W])
                    - int'(ref_cols[k+c][r*PIXEL_W +: PIXEL_W]);
                sum += (d < 0) ? -d : d;
            end
        end
        return sad_t'(sum);
    endfunction

    task automatic model_best(output sad_t exp_sad, output cand_idx_t exp_index);
        sad_t s;
        exp_sad   = model_sad(0);
        exp_index = '0;
        for (int k = 1; k < NUM_CAND; k++)
        begin
            s = model_sad(k);
            if (s < exp_sad)                    // Lowest index keeps a tie
            begin
                exp_sad   = s;
                exp_index = cand_idx_t'(k);
            end
        end
    endtask

    task automatic fill_random();
        for (int r = 0; r < BLOCK_EDGE; r++)
        begin
            cur_rows[r] = rand_bits(ROW_W);
        end
        for (int k = 0; k < WINDOW_COLS; k++)
        begin
            ref_cols[k] = rand_bits(ROW_W);
        end
    endtask

    // Candidate k becomes an exact copy of the current block
    task automatic place_copy(input int k);
        for (int c = 0; c < BLOCK_EDGE; c++)
        begin
            for (int r = 0; r < BLOCK_EDGE; r++)
            begin
                ref_cols[k+c][r*PIXEL_W +: PIXEL_W] = cur_rows[r][c*PIXEL_W +: PIXEL_W];
            end
        end
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_sad(input string name, input sad_t exp, input sad_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected sad %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_index(input string name, input cand_idx_t exp, input cand_idx_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected index %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (act != exp)
        begin
            errors++;
            $display("FAILED %s: expected %0d cycles, actual %0d", name, exp, act);
        end
    endtask

    // ------------------------------------------------------------
    // Block driver
    // ------------------------------------------------------------
    task automatic run_block(input string name, input logic noise, input logic dense,
                             output sad_t got_sad, output cand_idx_t got_index);
        int        cur_idx;
        int        ref_idx;
        int        cycles;
        int        latency;
        logic      seen;
        sad_t      exp_sad;
        cand_idx_t exp_index;
        cur_idx   = 0;
        ref_idx   = 0;
        cycles    = 0;
        got_sad   = '0;
        got_index = '0;
        model_best(exp_sad, exp_index);
        while (ref_idx < WINDOW_COLS && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
            cur_valid = 1'b0;
            ref_valid = 1'b0;
            if (need_cur && cur_idx < BLOCK_EDGE)
            begin
                if (dense || rand_bits(2) != 0)   // Random idle gaps
                begin
                    cur_in    = cur_rows[cur_idx];
                    cur_valid = 1'b1;
                    cur_idx++;
                end
            end
            else if (!need_cur && noise && rand_bits(1) == 1)
            begin
                cur_in    = rand_bits(ROW_W);     // Must be dropped
                cur_valid = 1'b1;
            end
            if (need_ref && ref_idx < WINDOW_COLS)
            begin
                if (dense || rand_bits(2) != 0)
                begin
                    ref_in    = ref_cols[ref_idx];
                    ref_valid = 1'b1;
                    ref_idx++;
                end
            end
            else if (!need_ref && noise && rand_bits(1) == 1)
            begin
                ref_in    = rand_bits(ROW_W);
                ref_valid = 1'b1;
            end
        end
        if (ref_idx < WINDOW_COLS)
        begin
            $display("%s: timeout waiting for the DUT to request all rows and columns", name);
            hung = 1'b1;
            return;
        end
        latency = 0;
        seen    = 1'b0;
        while (!seen && latency < WAIT_LIMIT)
        begin
            @(negedge clk);
            cur_valid = 1'b0;
            ref_valid = 1'b0;
            latency++;
            seen = result_valid;
        end
        if (!seen)
        begin
            $display("%s: timeout waiting for result_valid after the last column", name);
            hung = 1'b1;
            return;
        end
        got_sad   = best_sad;
        got_index = best_index;
        check_count({name, " latency"}, RESULT_LATENCY, latency);
        check_sad(name, exp_sad, best_sad);
        check_index(name, exp_index, best_index);
        @(negedge clk);
        check_bit({name, " result pulse"}, 1'b0, result_valid);
        cycles = 0;
        while (!need_cur && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!need_cur)
        begin
            $display("%s: timeout waiting for need_cur to return high", name);
            hung = 1'b1;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        if (hung)
            $display("%-16s stopped by a timeout", name);
        else if (errors == errors_before)
            $display("%-16s ok", name);
        else
            $display("%-16s %0d errors", name, errors - errors_before);
    endtask

    // ------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------
    task automatic test_reset();
        int e0;
        e0 = errors;
        check_bit("reset need_cur", 1'b1, need_cur);
        check_bit("reset need_ref", 1'b0, need_ref);
        check_bit("reset result_valid", 1'b0, result_valid);
        finish_test("reset", e0);
    endtask

    task automatic test_random();
        int        e0;
        sad_t      s;
        cand_idx_t i;
        e0 = errors;
        for (int n = 0; n < 10 && !hung; n++)
        begin
            fill_random();
            run_block($sformatf("random %0d", n), 1'b0, 1'b0, s, i);
        end
        finish_test("random", e0);
    endtask

    task automatic test_ties();
        int        e0;
        sad_t      s;
        cand_idx_t i;
        e0 = errors;
        fill_random();
        place_copy(5);
        place_copy(12);                         // Same SAD as candidate 5
        run_block("ties", 1'b0, 1'b0, s, i);
        check_index("ties lower index", cand_idx_t'(5), i);
        finish_test("ties", e0);
    endtask

    task automatic test_extremes();
        int        e0;
        sad_t      s;
        cand_idx_t i;
        e0 = errors;
        for (int r = 0; r < BLOCK_EDGE; r++)
        begin
            cur_rows[r] = '0;
        end
        for (int k = 0; k < WINDOW_COLS; k++)
        begin
            ref_cols[k] = '1;
        end
        run_block("extreme max", 1'b0, 1'b0, s, i);
        check_sad("extreme max sad", sad_t'(4080), s);
        check_index("extreme max index", '0, i);
        if (!hung)
        begin
            fill_random();
            place_copy(9);
            run_block("exact copy", 1'b0, 1'b0, s, i);
            check_sad("exact copy sad", '0, s);
            check_index("exact copy index", cand_idx_t'(9), i);
        end
        finish_test("extremes", e0);
    endtask

    task automatic test_ignored();
        int        e0;
        sad_t      s;
        cand_idx_t i;
        e0 = errors;
        for (int n = 0; n < 3 && !hung; n++)
        begin
            fill_random();
            run_block($sformatf("ignored %0d", n), 1'b1, 1'b0, s, i);
        end
        finish_test("ignored strobes", e0);
    endtask

    task automatic test_back_to_back();
        int        e0;
        sad_t      s;
        cand_idx_t i;
        e0 = errors;
        for (int n = 0; n < 2 && !hung; n++)
        begin
            fill_random();
            run_block($sformatf("back to back %0d", n), 1'b0, 1'b1, s, i);
        end
        finish_test("back to back", e0);
    endtask

    initial
    begin
        lfsr_state = 32'h179e_afbc;
        checks     = 0;
        errors     = 0;
        tests      = 0;
        hung       = 1'b0;
        rst        = 1'b1;
        cur_in     = '0;
        cur_valid  = 1'b0;
        ref_in     = '0;
        ref_valid  = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        test_reset();
        if (!hung)
            test_random();
        if (!hung)
            test_ties();
        if (!hung)
            test_extremes();
        if (!hung)
            test_ignored();
        if (!hung)
            test_back_to_back();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0 && !hung)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: verilog.f
design/me_pkg.sv
design/me_if.sv
design/cur_buffer.sv
design/ref_window.sv
design/sad_array.sv
design/min_select.sv
design/me_top.sv
test/tb_me_top.sv
